// ==== hw/frontendPkg.sv ====
`default_nettype none

package frontendPkg;

	////////////////////////////////
	// widths and fixed words
	////////////////////////////////

	localparam int Xlen = 32; // data and address width
	localparam logic [Xlen-1:0] Nop = 32'h0000_0013; // addi x0, x0, 0

	// axi write response codes
	localparam logic [1:0] RespOkay = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

	// next pc choice
	typedef enum logic [1:0] {
		PcSeq = 2'b00, // pc + 4
		PcZero = 2'b01, // restart at zero
		PcTarget = 2'b10, // branch or jump target
		PcHold = 2'b11 // repeat current pc
	} pcSel_e;

	////////////////////////////////
	// fetch address, two views
	////////////////////////////////

	typedef struct packed {
		logic [29:0] wordIdx; // bank bits low, row bits above
		logic [1:0] byteOff; // nonzero means misaligned
	} addrFields_t;

	typedef union packed {
		logic [Xlen-1:0] raw; // byte address
		addrFields_t fields;
	} fetchAddr_u;

	typedef struct packed {
		fetchAddr_u addr;
		logic en; // read enable, low on stall
		logic misaligned;
	} fetchReq_t;

	typedef struct packed {
		logic en;
		logic [29:0] wordIdx; // global word index
		logic [Xlen-1:0] data;
	} bankWrite_t;

	typedef struct packed {
		logic valid;
		logic [Xlen-1:0] pc;
		logic [Xlen-1:0] instr;
		logic misaligned;
	} fetchOut_t;

	////////////////////////////////
	// axi4-lite write channels
	////////////////////////////////

	typedef struct packed {
		logic [Xlen-1:0] awaddr;
		logic awvalid;
		logic [Xlen-1:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
	} axiLiteWReq_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
	} axiLiteWResp_t;

endpackage

`default_nettype wire

// ==== hw/pcGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pcGen (
	input wire logic clk,
	input wire logic nrst,
	input wire logic stall, // freezes the pc, not the trap
	input wire frontendPkg::pcSel_e pcSel,
	input wire logic [frontendPkg::Xlen-1:0] target,
	input wire logic exceptionPending,
	input wire logic [frontendPkg::Xlen-1:0] trapVector,
	output frontendPkg::fetchReq_t req
);
	import frontendPkg::*;

	logic [Xlen-1:0] pc; // current fetch address
	logic [Xlen-1:0] nextPc;
	logic trapSeen; // exceptionPending one cycle back
	logic trapFire; // rising edge of exceptionPending
	fetchAddr_u curAddr;

	// one redirect per pending exception
	assign trapFire = exceptionPending && !trapSeen;

	////////////////////////////////
	// next pc selection
	////////////////////////////////

	always_comb
	begin
		if (trapFire)
		begin
			nextPc = trapVector; // trap wins, even under stall
		end
		else if (stall)
		begin
			nextPc = pc;
		end
		else
		begin
			case (pcSel)
				PcSeq: nextPc = pc + Xlen'(4);
				PcZero: nextPc = '0;
				PcTarget: nextPc = target;
				PcHold: nextPc = pc;
				default: nextPc = pc + Xlen'(4);
			endcase
		end
	end

	// pc and trap edge detect
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc <= '0; // first fetch is address zero
			trapSeen <= 1'b0;
		end
		else
		begin
			pc <= nextPc;
			trapSeen <= exceptionPending; // rearms once pending drops
		end
	end

	////////////////////////////////
	// request to banks and return
	////////////////////////////////

	assign curAddr.raw = pc;

	always_comb
	begin
		req.addr = curAddr;
		req.en = !stall;
		// byte offset decoded through the union view
		req.misaligned = (curAddr.fields.byteOff != 2'b00);
	end

	// a trap vector must always land on a word
	trapVecAligned: assert property (
		@(posedge clk) disable iff (!nrst)
		exceptionPending |-> (trapVector[1:0] == 2'b00)
	) else $error("trap vector not word aligned");

endmodule

`default_nettype wire

// ==== hw/imemLoader.sv ====
`timescale 1ns/10ps
`default_nettype none

module imemLoader #(
	parameter int NumBanks = 4,
	parameter int BankDepth = 64
) (
	input wire logic clk,
	input wire logic nrst,
	input wire frontendPkg::axiLiteWReq_t axiReq,
	output frontendPkg::axiLiteWResp_t axiResp,
	output frontendPkg::bankWrite_t bankWr
);
	import frontendPkg::*;

	localparam int NumWords = NumBanks * BankDepth; // whole memory in words

	// channel holding state
	logic awHeld; // address channel latched
	logic wHeld; // data channel latched
	logic busy; // request checked, waiting for response handshake
	logic fire; // both held, check now
	logic reqGood;
	logic issued; // one cycle after the check
	logic bvalid;
	logic [1:0] respCode;

	// payload latches
	logic [29:0] idxReg;
	logic [Xlen-1:0] dataReg;
	logic [3:0] strbReg;

	// registered bank write
	logic wrEn;
	logic [29:0] wrIdx;
	logic [Xlen-1:0] wrData;

	logic awAccept;
	logic wAccept;
	logic respDone;

	assign awAccept = axiReq.awvalid && !awHeld;
	assign wAccept = axiReq.wvalid && !wHeld;
	assign respDone = bvalid && axiReq.bready;

	assign fire = awHeld && wHeld && !busy;
	// full strobe and index inside the banks
	assign reqGood = (strbReg == 4'hF) && ({2'b00, idxReg} < NumWords);

	////////////////////////////////
	// control state
	////////////////////////////////

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			awHeld <= 1'b0;
			wHeld <= 1'b0;
			busy <= 1'b0;
			issued <= 1'b0;
			wrEn <= 1'b0;
			bvalid <= 1'b0;
			respCode <= RespOkay;
		end
		else
		begin
			if (awAccept)
				awHeld <= 1'b1;
			if (wAccept)
				wHeld <= 1'b1;
			wrEn <= fire && reqGood; // single cycle pulse
			issued <= fire;
			if (fire)
			begin
				busy <= 1'b1;
				respCode <= reqGood ? RespOkay : RespSlvErr;
			end
			if (issued)
				bvalid <= 1'b1; // two cycles after both accepted
			if (respDone)
			begin
				// reopen both channels
				bvalid <= 1'b0;
				awHeld <= 1'b0;
				wHeld <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk)
	begin
		if (awAccept)
			idxReg <= axiReq.awaddr[31:2]; // byte to word address
		if (wAccept)
		begin
			dataReg <= axiReq.wdata;
			strbReg <= axiReq.wstrb;
		end
		if (fire)
		begin
			wrIdx <= idxReg;
			wrData <= dataReg;
		end
	end

	////////////////////////////////
	// outputs
	////////////////////////////////

	always_comb
	begin
		axiResp.awready = !awHeld;
		axiResp.wready = !wHeld;
		axiResp.bvalid = bvalid;
		axiResp.bresp = respCode;
		bankWr.en = wrEn;
		bankWr.wordIdx = wrIdx;
		bankWr.data = wrData;
	end

	// response must wait for the master
	bvalidHold: assert property (
		@(posedge clk) disable iff (!nrst)
		(axiResp.bvalid && !axiReq.bready) |=>
			(axiResp.bvalid && $stable(axiResp.bresp))
	) else $error("bvalid dropped before bready");

	// one bank write per accepted request
	wrPulse: assert property (
		@(posedge clk) disable iff (!nrst)
		bankWr.en |=> !bankWr.en
	) else $error("bank write longer than one cycle");

endmodule

`default_nettype wire

// ==== hw/imemBank.sv ====
`timescale 1ns/10ps
`default_nettype none

module imemBank #(
	parameter int BankId = 0,
	parameter int NumBanks = 4,
	parameter int BankDepth = 64
) (
	input wire logic clk,
	input wire frontendPkg::fetchReq_t req,
	input wire frontendPkg::bankWrite_t wr,
	output logic [frontendPkg::Xlen-1:0] rdata
);
	import frontendPkg::*;

	localparam int BankBits = $clog2(NumBanks); // low word index bits
	localparam int RowBits = $clog2(BankDepth);

	logic [Xlen-1:0] mem [BankDepth]; // storage, no reset

	logic wrHit; // write addressed to this bank
	logic [RowBits-1:0] wrRow;
	logic [RowBits-1:0] rdRow;

	// interleave on the low word bits
	assign wrHit = wr.en && (wr.wordIdx[BankBits-1:0] == BankBits'(BankId));
	assign wrRow = wr.wordIdx[BankBits +: RowBits];
	assign rdRow = req.addr.fields.wordIdx[BankBits +: RowBits];

	////////////////////////////////
	// write port and read port
	////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wrHit)
		begin
			mem[wrRow] <= wr.data;
		end
		if (req.en)
		begin
			// same row same cycle reads old word
			rdata <= mem[rdRow];
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetchReturn.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetchReturn #(
	parameter int NumBanks = 4
) (
	input wire logic clk,
	input wire logic nrst,
	input wire frontendPkg::fetchReq_t req,
	input wire logic [frontendPkg::Xlen-1:0] bankData [NumBanks],
	output frontendPkg::fetchOut_t out
);
	import frontendPkg::*;

	localparam int BankBits = $clog2(NumBanks);

	logic [BankBits-1:0] bankSel; // bank of the word in flight
	logic [Xlen-1:0] pcReg;
	logic misReg;
	logic validReg; // set by first enabled fetch

	////////////////////////////////
	// align with the bank read
	////////////////////////////////

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			bankSel <= '0;
			misReg <= 1'b0;
			validReg <= 1'b0;
		end
		else if (req.en) // stall holds everything
		begin
			bankSel <= req.addr.fields.wordIdx[BankBits-1:0];
			misReg <= req.misaligned;
			validReg <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req.en)
			pcReg <= req.addr.raw;
	end

	// selected bank, nop for bad alignment
	always_comb
	begin
		out.valid = validReg;
		out.pc = pcReg;
		out.instr = misReg ? Nop : bankData[bankSel];
		out.misaligned = misReg;
	end

endmodule

`default_nettype wire

// ==== hw/frontendTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontendTop #(
	parameter int NumBanks = 4, // power of two
	parameter int BankDepth = 64 // rows per bank
) (
	input wire logic clk,
	input wire logic nrst,
	input wire logic stall,
	input wire frontendPkg::pcSel_e pcSel,
	input wire logic [frontendPkg::Xlen-1:0] target,
	input wire logic exceptionPending,
	input wire logic [frontendPkg::Xlen-1:0] trapVector,
	input wire frontendPkg::axiLiteWReq_t axiReq,
	output frontendPkg::axiLiteWResp_t axiResp,
	output frontendPkg::fetchOut_t fetch
);
	import frontendPkg::*;

	fetchReq_t req; // pc to banks and return
	bankWrite_t bankWr; // loader to every bank
	logic [Xlen-1:0] bankData [NumBanks];

	////////////////////////////////
	// pc and loader
	////////////////////////////////

	pcGen u_pcGen (
		.clk(clk),
		.nrst(nrst),
		.stall(stall),
		.pcSel(pcSel),
		.target(target),
		.exceptionPending(exceptionPending),
		.trapVector(trapVector),
		.req(req)
	);

	imemLoader #(
		.NumBanks(NumBanks),
		.BankDepth(BankDepth)
	) u_imemLoader (
		.clk(clk),
		.nrst(nrst),
		.axiReq(axiReq),
		.axiResp(axiResp),
		.bankWr(bankWr)
	);

	// interleaved banks
	for (genvar b = 0; b < NumBanks; b++)
	begin : gBank
		imemBank #(
			.BankId(b),
			.NumBanks(NumBanks),
			.BankDepth(BankDepth)
		) u_imemBank (
			.clk(clk),
			.req(req),
			.wr(bankWr),
			.rdata(bankData[b])
		);
	end

	fetchReturn #(
		.NumBanks(NumBanks)
	) u_fetchReturn (
		.clk(clk),
		.nrst(nrst),
		.req(req),
		.bankData(bankData),
		.out(fetch)
	);

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int Period = 8, // ns
	parameter int ResetCycles = 4
) (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial
	begin
		nrst = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		nrst = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/frontendTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontendTb;
	import frontendPkg::*;

	localparam int ClkPeriod = 8;
	localparam int NumBanks = 4;
	localparam int BankDepth = 64;
	localparam int NumWords = NumBanks * BankDepth;
	localparam int RandWrites = 32;
	localparam int RandFetches = 32;

	////////////////////////////////
	// run length budget
	////////////////////////////////

	localparam int LoadCycles = NumWords * 12 + NumWords + 10; // load, then walk
	localparam int FetchTestCycles = 20 + 30 + 30; // stall, redirect, trap
	localparam int ErrCycles = 3 * 20 + 10;
	localparam int RandCycles = RandWrites * 12 + RandFetches * 2 + 10;
	localparam int BudgetCycles = 2 * (LoadCycles + FetchTestCycles + ErrCycles + RandCycles);

	logic clk;
	logic nrst;
	logic stall;
	pcSel_e pcSel;
	logic [Xlen-1:0] target;
	logic exceptionPending;
	logic [Xlen-1:0] trapVector;
	axiLiteWReq_t axiReq;
	axiLiteWResp_t axiResp;
	fetchOut_t fetch;

	logic [Xlen-1:0] shadow [NumWords]; // words loaded so far
	logic [Xlen-1:0] modelPc; // pc the DUT should hold
	logic excPrev; // last exceptionPending driven
	logic expValid;
	logic [Xlen-1:0] expPc;
	logic [Xlen-1:0] expInstr;
	logic expMis;
	logic [31:0] lcgState;

	clockGen #(
		.Period(ClkPeriod),
		.ResetCycles(4)
	) u_clockGen (
		.clk(clk),
		.nrst(nrst)
	);

	frontendTop #(
		.NumBanks(NumBanks),
		.BankDepth(BankDepth)
	) u_frontendTop (
		.clk(clk),
		.nrst(nrst),
		.stall(stall),
		.pcSel(pcSel),
		.target(target),
		.exceptionPending(exceptionPending),
		.trapVector(trapVector),
		.axiReq(axiReq),
		.axiResp(axiResp),
		.fetch(fetch)
	);

	////////////////////////////////
	// helpers
	////////////////////////////////

	function automatic logic [31:0] randWord();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// every bit of the index shows up in the word
	function automatic logic [Xlen-1:0] fillWord(input int idx);
		return (idx * 32'h9E37_79B1) ^ 32'h0F1E_2D3C;
	endfunction

	function automatic int wordOf(input logic [Xlen-1:0] addr);
		return (addr >> 2) % NumWords; // banks wrap on the row bits
	endfunction

	task automatic expectEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "check mismatch, run stopped");
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1; // inputs move 1 ns after the edge
	endtask

	// hold valid on each chosen channel until its ready was seen
	task automatic sendChannels(input logic doAw, input logic doW);
		logic awHit;
		logic wHit;
		begin
			axiReq.awvalid = doAw;
			axiReq.wvalid = doW;
			while (axiReq.awvalid || axiReq.wvalid)
			begin
				awHit = axiReq.awvalid && axiResp.awready;
				wHit = axiReq.wvalid && axiResp.wready;
				nextCycle();
				if (awHit)
					axiReq.awvalid = 1'b0;
				if (wHit)
					axiReq.wvalid = 1'b0;
			end
		end
	endtask

	// order 0 addr first, 1 data first, 2 both together
	task automatic axiWrite(input logic [Xlen-1:0] addr, input logic [Xlen-1:0] data,
			input logic [3:0] strb, input int order, input int gap, input int hold,
			output logic [1:0] resp);
		int lat;
		begin
			axiReq.awaddr = addr;
			axiReq.wdata = data;
			axiReq.wstrb = strb;
			if (order == 0)
			begin
				sendChannels(1'b1, 1'b0);
				repeat (gap) nextCycle();
				sendChannels(1'b0, 1'b1);
			end
			else if (order == 1)
			begin
				sendChannels(1'b0, 1'b1);
				repeat (gap) nextCycle();
				sendChannels(1'b1, 1'b0);
			end
			else
				sendChannels(1'b1, 1'b1);
			lat = 0;
			while (!axiResp.bvalid)
			begin
				nextCycle();
				lat++;
			end
			expectEq(lat, 2, "write response latency");
			resp = axiResp.bresp;
			// bready low, response must stay put
			repeat (hold)
			begin
				nextCycle();
				expectEq(axiResp.bvalid, 1'b1, "bvalid under back-pressure");
				expectEq(axiResp.bresp, resp, "bresp under back-pressure");
				expectEq(axiResp.awready, 1'b0, "awready while response pending");
				expectEq(axiResp.wready, 1'b0, "wready while response pending");
			end
			axiReq.bready = 1'b1;
			nextCycle();
			axiReq.bready = 1'b0;
			expectEq(axiResp.bvalid, 1'b0, "bvalid after handshake");
		end
	endtask

	// one fetch cycle, checks what the previous pc delivered
	task automatic fetchStep(input logic stallIn, input pcSel_e sel,
			input logic [Xlen-1:0] tgt, input logic exc);
		logic fire;
		begin
			stall = stallIn;
			pcSel = sel;
			target = tgt;
			exceptionPending = exc;
			if (!stallIn)
			begin
				expValid = 1'b1;
				expPc = modelPc;
				expMis = (modelPc[1:0] != 2'b00);
				expInstr = expMis ? Nop : shadow[wordOf(modelPc)];
			end
			fire = exc && !excPrev; // trap only on the rising edge
			if (fire)
				modelPc = trapVector;
			else if (!stallIn)
			begin
				case (sel)
					PcSeq: modelPc = modelPc + 32'd4;
					PcZero: modelPc = '0;
					PcTarget: modelPc = tgt;
					default: modelPc = modelPc; // hold
				endcase
			end
			excPrev = exc;
			nextCycle();
			expectEq(fetch.valid, expValid, "fetch valid");
			expectEq(fetch.pc, expPc, "fetch pc");
			expectEq(fetch.instr, expInstr, "fetch instr");
			expectEq(fetch.misaligned, expMis, "fetch misaligned");
		end
	endtask

	task automatic seqSteps(input int n);
		repeat (n) fetchStep(1'b0, PcSeq, '0, 1'b0);
	endtask

	////////////////////////////////
	// tests
	////////////////////////////////

	task automatic loadAndSequential();
		logic [1:0] resp;
		begin
			stall = 1'b1; // pc parked at zero while loading
			for (int i = 0; i < NumWords; i++)
			begin
				shadow[i] = fillWord(i);
				axiWrite(i * 4, shadow[i], 4'hF, i % 3, (i / 3) % 3, 0, resp);
				expectEq(resp, RespOkay, "load response");
			end
			expectEq(fetch.valid, 1'b0, "valid before first fetch");
			seqSteps(NumWords + 8); // walks every bank, wraps once
		end
	endtask

	task automatic stallHold();
		seqSteps(3);
		repeat (4) fetchStep(1'b1, PcSeq, '0, 1'b0);
		seqSteps(4);
		fetchStep(1'b1, PcTarget, 32'h40, 1'b0); // target ignored under stall
		seqSteps(3);
	endtask

	task automatic redirects();
		fetchStep(1'b0, PcTarget, 32'h100, 1'b0);
		seqSteps(3);
		fetchStep(1'b0, PcTarget, 32'h202, 1'b0); // odd byte offset
		seqSteps(3);
		fetchStep(1'b0, PcZero, '0, 1'b0);
		seqSteps(3);
		fetchStep(1'b0, PcHold, '0, 1'b0);
		fetchStep(1'b0, PcHold, '0, 1'b0);
		seqSteps(3);
	endtask

	task automatic trapOnce();
		trapVector = 32'h300;
		seqSteps(2);
		fetchStep(1'b0, PcSeq, '0, 1'b1);
		fetchStep(1'b1, PcSeq, '0, 1'b1);
		fetchStep(1'b1, PcSeq, '0, 1'b1);
		fetchStep(1'b0, PcSeq, '0, 1'b1); // still pending, no second redirect
		fetchStep(1'b0, PcTarget, 32'h80, 1'b1);
		fetchStep(1'b0, PcSeq, '0, 1'b0);
		seqSteps(3);
		// rise under stall still redirects
		trapVector = 32'h3C0;
		fetchStep(1'b1, PcSeq, '0, 1'b1);
		fetchStep(1'b1, PcSeq, '0, 1'b1);
		fetchStep(1'b0, PcSeq, '0, 1'b0);
		seqSteps(4);
	endtask

	task automatic axiErrors();
		logic [1:0] resp;
		begin
			stall = 1'b1;
			axiWrite(32'd40, 32'hDEAD_BEEF, 4'h3, 2, 0, 0, resp);
			expectEq(resp, RespSlvErr, "partial strobe response");
			// index NumWords aliases row 0 of bank 0
			axiWrite(NumWords * 4, 32'hBADC_0DE5, 4'hF, 0, 1, 0, resp);
			expectEq(resp, RespSlvErr, "out of range response");
			axiWrite(32'd80, 32'hC001_D00D, 4'hF, 1, 2, 5, resp);
			expectEq(resp, RespOkay, "back-pressured write response");
			shadow[20] = 32'hC001_D00D;
			axiWrite(32'd44, 32'h1111_2222, 4'h8, 0, 0, 3, resp);
			expectEq(resp, RespSlvErr, "back-pressured error response");
			fetchStep(1'b0, PcTarget, 32'd40, 1'b0);
			fetchStep(1'b0, PcSeq, '0, 1'b0); // word 10 unchanged
			fetchStep(1'b0, PcZero, '0, 1'b0); // word 11 unchanged
			fetchStep(1'b0, PcTarget, 32'd80, 1'b0); // word 0 unchanged
			seqSteps(3); // word 20 rewritten
		end
	endtask

	task automatic randomLoadFetch();
		logic [1:0] resp;
		int idx;
		logic [Xlen-1:0] data;
		begin
			stall = 1'b1;
			for (int i = 0; i < RandWrites; i++)
			begin
				idx = randWord() % NumWords;
				data = randWord();
				shadow[idx] = data;
				axiWrite(idx * 4, data, 4'hF, randWord() % 3, randWord() % 3, 0, resp);
				expectEq(resp, RespOkay, "random load response");
			end
			for (int i = 0; i < RandFetches; i++)
			begin
				idx = randWord() % NumWords;
				fetchStep(1'b0, PcTarget, idx * 4, 1'b0);
				fetchStep(1'b0, PcSeq, '0, 1'b0);
			end
		end
	endtask

	////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////

	initial
	begin
		stall = 1'b1;
		pcSel = PcSeq;
		target = '0;
		exceptionPending = 1'b0;
		trapVector = '0;
		axiReq = '0;
		modelPc = '0;
		excPrev = 1'b0;
		expValid = 1'b0;
		expPc = '0;
		expInstr = '0;
		expMis = 1'b0;
		lcgState = 32'd78; // fixed seed
		@(posedge nrst);
		expectEq(axiResp.awready, 1'b1, "awready after reset");
		expectEq(axiResp.wready, 1'b1, "wready after reset");
		expectEq(axiResp.bvalid, 1'b0, "bvalid after reset");
		expectEq(fetch.valid, 1'b0, "fetch valid after reset");
		loadAndSequential();
		stallHold();
		redirects();
		trapOnce();
		axiErrors();
		randomLoadFetch();
		$display("TEST PASSED");
		$finish;
	end

	initial
	begin
		#(BudgetCycles * ClkPeriod);
		$display("timeout: the tests did not finish within %0d cycles", BudgetCycles);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/frontendPkg.sv
hw/pcGen.sv
hw/imemLoader.sv
hw/imemBank.sv
hw/fetchReturn.sv
hw/frontendTop.sv
tests/clockGen.sv
tests/frontendTb.sv
